// File: mips_core.f
verilog/mips_pkg.sv
verilog/pipe_reg.sv
verilog/fetch_unit.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/hazard_forward.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/mips_core.sv
bench/mips_core_tb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - verilog/mips_pkg.sv
  - verilog/pipe_reg.sv
  - verilog/fetch_unit.sv
  - verilog/control_unit.sv
  - verilog/reg_file.sv
  - verilog/hazard_forward.sv
  - verilog/alu.sv
  - verilog/data_memory.sv
  - verilog/mips_core.sv
  - target: simulation
    files:
      - bench/mips_core_tb.sv

// File: bench/mips_core_tb.sv
// Testbench for the MIPS pipeline core
`timescale 1ns/10ps

module mips_core_tb;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int ROM_WORDS    = 64;
    localparam logic [31:0] SYSCALL_INST = {OP_RTYPE, 20'h0, FN_SYSCALL};

    logic        clk;
    logic        rst;
    logic [31:0] imem_inst;
    logic [31:0] imem_addr;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        overflow;
    logic        syscall;

    logic [31:0] rom [ROM_WORDS];   // Instruction ROM model
    logic [31:0] prog [$];          // Program under construction
    logic [4:0]  exp_addr [$];      // Expected write-back sequence
    logic [31:0] exp_data [$];
    logic        exp_ovf [$];
    int          exp_ovf_total;
    integer      seed = 32'hecb62acc;
    int          budget_cycles = 0;  // Grows as each program is loaded
    int          elapsed_cycles = 0;

    // Same-cycle fetch, syscall beyond the ROM
    assign imem_inst = (imem_addr < ROM_WORDS * 4) ? rom[imem_addr[7:2]] : SYSCALL_INST;

    mips_core mips_core_inst (
        .clk       (clk),
        .rst       (rst),
        .imem_inst (imem_inst),
        .imem_addr (imem_addr),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .overflow  (overflow),
        .syscall   (syscall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog, budget summed per program
    initial begin
        while (elapsed_cycles <= budget_cycles) begin
            @(posedge clk);
            elapsed_cycles++;
        end
        $display("error: program never reached syscall within %0d cycles", budget_cycles);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    // ====================
    // Helpers
    function automatic logic [31:0] r_inst(funct_e fn, int rd, int rs, int rt);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_inst(opcode_e op, int rt, int rs, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] j_inst(int index);
        return {OP_J, 26'(index)};
    endfunction

    // True when the exact sum does not fit in 32 signed bits
    function automatic logic wraps(longint exact);
        logic signed [31:0] low;
        low = exact[31:0];
        return exact != low;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%08h got 0x%08h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // In-order ISA model of the ROM program
    task automatic model_program();
        logic [31:0] regs [32];
        logic [31:0] dmem [logic [31:0]];
        logic [31:0] pc, next, inst, a, b, sext, res;
        logic [4:0]  dst;
        logic        wr, ovf;
        int          steps;
        foreach (regs[i]) regs[i] = '0;
        exp_addr.delete();
        exp_data.delete();
        exp_ovf.delete();
        exp_ovf_total = 0;
        pc = '0;
        steps = 0;
        while (steps < 200) begin
            inst = (pc < ROM_WORDS * 4) ? rom[pc[7:2]] : SYSCALL_INST;
            a    = regs[inst[25:21]];
            b    = regs[inst[20:16]];
            sext = {{16{inst[15]}}, inst[15:0]};
            dst  = inst[20:16];  // rt unless R-type
            wr   = 1'b1;
            ovf  = 1'b0;
            res  = '0;
            next = pc + 32'd4;
            case (inst[31:26])
                OP_RTYPE: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        FN_ADD: begin
                            res = a + b;
                            ovf = wraps(longint'($signed(a)) + longint'($signed(b)));
                        end
                        FN_SUB: begin
                            res = a - b;
                            ovf = wraps(longint'($signed(a)) - longint'($signed(b)));
                        end
                        FN_AND:     res = a & b;
                        FN_OR:      res = a | b;
                        FN_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SYSCALL: return;  // End of program
                        default:    wr = 1'b0;
                    endcase
                end
                OP_ADDI: begin
                    res = a + sext;
                    ovf = wraps(longint'($signed(a)) + longint'($signed(sext)));
                end
                OP_LUI: res = {inst[15:0], 16'h0};
                OP_LW:  res = dmem[(a + sext) >> 2];
                OP_SW: begin
                    dmem[(a + sext) >> 2] = b;
                    wr = 1'b0;
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b)
                        next = pc + 32'd4 + (sext << 2);
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != b)
                        next = pc + 32'd4 + (sext << 2);
                end
                OP_J: begin
                    wr   = 1'b0;
                    next = {next[31:28], inst[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin  // $zero never written
                regs[dst] = res;
                exp_addr.push_back(dst);
                exp_data.push_back(res);
                exp_ovf.push_back(ovf);
                exp_ovf_total += int'(ovf);
            end
            pc = next;
            steps++;
        end
        $display("error: reference model ran 200 steps without reaching syscall");
        $display("TB FAILED");
        $fatal(1, "runaway program");
    endtask

    // Load ROM, reset core, log write-backs until syscall
    task automatic run_program(string name);
        int   n_wb;
        int   n_ovf;
        logic ovf_d1, ovf_d2;
        budget_cycles += 3 * prog.size() + 20 + RESET_CYCLES + 1;
        foreach (rom[i]) rom[i] = (i < prog.size()) ? prog[i] : SYSCALL_INST;
        model_program();
        @(posedge clk);
        rst <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);  // Reset state settled
        check_value("imem_addr", RESET_PC, imem_addr);
        check_value("wb_en", 1'b0, wb_en);
        check_value("overflow", 1'b0, overflow);
        check_value("syscall", 1'b0, syscall);
        @(posedge clk);
        rst <= 1'b0;
        n_wb   = 0;
        n_ovf  = 0;
        ovf_d1 = 1'b0;
        ovf_d2 = 1'b0;
        do begin
            @(negedge clk);  // Outputs settled mid-cycle
            if (wb_en) begin
                // Extra write-back beyond the model
                check_value("wb count", exp_addr.size(),
                            (n_wb < exp_addr.size()) ? exp_addr.size() : n_wb + 1);
                check_value("wb_addr", exp_addr[n_wb], wb_addr);
                check_value("wb_data", exp_data[n_wb], wb_data);
                check_value("overflow", exp_ovf[n_wb], ovf_d2);  // EX is two cycles before WB
                n_wb++;
            end
            if (overflow)
                n_ovf++;
            ovf_d2 = ovf_d1;
            ovf_d1 = overflow;
        end while (!syscall);
        check_value("wb count", exp_addr.size(), n_wb);  // Nothing left behind syscall
        check_value("overflow count", exp_ovf_total, n_ovf);
        $display("%s: %0d write-backs", name, n_wb);
        prog.delete();
    endtask

    // ====================
    // Directed programs
    task automatic dependent_arith();
        logic [15:0] k0, k1, k2;
        k0 = 16'($random(seed));
        k1 = 16'($random(seed));
        k2 = 16'($random(seed));
        prog.push_back(i_inst(OP_ADDI, 1, 0, k0));
        prog.push_back(i_inst(OP_LUI, 2, 0, k1));
        prog.push_back(r_inst(FN_ADD, 3, 1, 2));   // MEM and EX sources
        prog.push_back(r_inst(FN_SUB, 4, 3, 1));
        prog.push_back(r_inst(FN_AND, 5, 4, 3));
        prog.push_back(r_inst(FN_OR, 6, 5, 2));    // r2 from the register file
        prog.push_back(r_inst(FN_SLT, 7, 6, 4));
        prog.push_back(i_inst(OP_ADDI, 8, 7, k2));
        prog.push_back(SYSCALL_INST);
        run_program("dependent arithmetic");
    endtask

    task automatic memory_access();
        logic [15:0] k;
        k = 16'($random(seed));
        prog.push_back(i_inst(OP_ADDI, 1, 0, 16'h0040));  // Base address
        prog.push_back(i_inst(OP_ADDI, 2, 0, k));
        prog.push_back(i_inst(OP_SW, 2, 1, 16'h0000));
        prog.push_back(i_inst(OP_LW, 3, 1, 16'h0000));
        prog.push_back(r_inst(FN_ADD, 4, 3, 3));          // Load-use stall
        prog.push_back(i_inst(OP_SW, 4, 1, 16'h0004));
        prog.push_back(i_inst(OP_LW, 5, 1, 16'h0004));
        prog.push_back(r_inst(FN_SUB, 6, 5, 2));
        prog.push_back(SYSCALL_INST);
        run_program("memory");
    endtask

    task automatic branch_and_jump();
        prog.push_back(i_inst(OP_ADDI, 1, 0, 16'd5));
        prog.push_back(i_inst(OP_ADDI, 2, 0, 16'd5));
        prog.push_back(i_inst(OP_BEQ, 2, 1, 16'd1));      // Taken to 4
        prog.push_back(i_inst(OP_ADDI, 3, 0, 16'h0111));  // Squashed
        prog.push_back(i_inst(OP_BNE, 2, 1, 16'd1));      // Not taken
        prog.push_back(i_inst(OP_ADDI, 4, 0, 16'h0222));
        prog.push_back(i_inst(OP_BEQ, 1, 4, 16'd1));      // Not taken, r4 from EX
        prog.push_back(i_inst(OP_ADDI, 5, 0, 16'h0333));
        prog.push_back(i_inst(OP_BNE, 1, 5, 16'd1));      // Taken to 10
        prog.push_back(i_inst(OP_ADDI, 6, 0, 16'h0444));  // Squashed
        prog.push_back(j_inst(12));
        prog.push_back(i_inst(OP_ADDI, 7, 0, 16'h0555));  // Squashed
        prog.push_back(i_inst(OP_ADDI, 8, 0, 16'h0666));
        prog.push_back(SYSCALL_INST);
        run_program("control flow");
    endtask

    task automatic overflow_flag();
        prog.push_back(i_inst(OP_ADDI, 2, 0, 16'hffff));  // -1
        prog.push_back(i_inst(OP_LUI, 3, 0, 16'h8000));
        prog.push_back(r_inst(FN_SUB, 1, 2, 3));          // 0x7fffffff
        prog.push_back(i_inst(OP_ADDI, 4, 0, 16'd1));
        prog.push_back(r_inst(FN_ADD, 5, 1, 4));          // Wraps, still written
        prog.push_back(r_inst(FN_ADD, 6, 4, 4));
        prog.push_back(r_inst(FN_ADD, 7, 2, 4));
        prog.push_back(SYSCALL_INST);
        run_program("overflow");
    endtask

    task automatic zero_reg_and_syscall();
        prog.push_back(i_inst(OP_ADDI, 0, 0, 16'h0123));  // No write-back
        prog.push_back(i_inst(OP_ADDI, 1, 0, 16'd7));
        prog.push_back(r_inst(FN_ADD, 0, 1, 1));
        prog.push_back(r_inst(FN_ADD, 2, 0, 1));          // $zero must read zero
        prog.push_back(r_inst(FN_OR, 3, 0, 0));
        prog.push_back(i_inst(OP_SW, 1, 0, 16'h0008));
        prog.push_back(i_inst(OP_LW, 5, 0, 16'h0008));    // Last write right before syscall
        prog.push_back(SYSCALL_INST);
        run_program("register 0 and syscall");
    endtask

    // ====================
    initial begin
        rst = 1'b1;
        foreach (rom[i]) rom[i] = SYSCALL_INST;
        dependent_arith();
        memory_access();
        branch_and_jump();
        overflow_flag();
        zero_reg_and_syscall();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: verilog/mips_core.sv
// MIPS five-stage pipeline core
`timescale 1ns/10ps

module mips_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mips_pkg::XLEN-1:0]       imem_inst,
    output logic [mips_pkg::XLEN-1:0]       imem_addr,
    output logic                            wb_en,
    output logic [mips_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [mips_pkg::XLEN-1:0]       wb_data,
    output logic                            overflow,
    output logic                            syscall
);
    import mips_pkg::*;

    if_id_t  if_id_d,  if_id_q;
    id_ex_t  id_ex_d,  id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    logic [XLEN-1:0]       pc_plus_4;
    logic                  stall, redirect;
    ctrl_t                 id_ctrl;
    logic                  is_beq, is_bne, is_jump;
    logic [REG_ADDR_W-1:0] rs_id, rt_id;
    logic [XLEN-1:0]       rf_rdata0, rf_rdata1;
    logic [XLEN-1:0]       rs_val, rt_val;      // Decode operands after forwarding
    logic [XLEN-1:0]       ex_result, mem_result;

    // ====================
    // Fetch
    fetch_unit fetch_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_jump      (is_jump),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .imm          (if_id_q.inst[15:0]),
        .jump_index   (if_id_q.inst[25:0]),
        .pc_plus_4_id (if_id_q.pc_plus_4),
        .imem_addr    (imem_addr),
        .pc_plus_4    (pc_plus_4),
        .redirect     (redirect)
    );

    assign if_id_d = '{inst: imem_inst, pc_plus_4: pc_plus_4};

    pipe_reg #(.payload_t(if_id_t)) if_id_inst (
        .clk   (clk),
        .rst   (rst),
        .hold  (stall),     // Retry decode after load-use
        .flush (redirect),  // Squash the wrong-path slot
        .d     (if_id_d),
        .q     (if_id_q)
    );

    // ====================
    // Decode
    assign rs_id = if_id_q.inst[25:21];
    assign rt_id = if_id_q.inst[20:16];

    control_unit control_unit_inst (
        .clk     (clk),
        .rst     (rst),
        .inst    (if_id_q.inst),
        .ctrl    (id_ctrl),
        .is_beq  (is_beq),
        .is_bne  (is_bne),
        .is_jump (is_jump)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .rst    (rst),
        .wen    (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .raddr0 (rs_id),
        .raddr1 (rt_id),
        .rdata0 (rf_rdata0),
        .rdata1 (rf_rdata1)
    );

    hazard_forward hazard_forward_inst (
        .clk        (clk),
        .rst        (rst),
        .rs_id      (rs_id),
        .rt_id      (rt_id),
        .ex_ctrl    (id_ex_q.ctrl),
        .mem_ctrl   (ex_mem_q.ctrl),
        .wb_ctrl    (mem_wb_q.ctrl),
        .rf_rdata0  (rf_rdata0),
        .rf_rdata1  (rf_rdata1),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .wb_data    (wb_data),
        .stall      (stall),
        .rs_val     (rs_val),
        .rt_val     (rt_val)
    );

    assign id_ex_d = '{ctrl: id_ctrl, rs_val: rs_val, rt_val: rt_val,
                       imm: if_id_q.inst[15:0], rt: rt_id};

    pipe_reg #(.payload_t(id_ex_t)) id_ex_inst (
        .clk   (clk),
        .rst   (rst),
        .hold  (1'b0),
        .flush (stall),  // Bubble into EX while decode waits
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // ====================
    // Execute
    alu alu_inst (
        .ctrl     (id_ex_q.ctrl),
        .rs_val   (id_ex_q.rs_val),
        .rt_val   (id_ex_q.rt_val),
        .imm      (id_ex_q.imm),
        .result   (ex_result),
        .overflow (overflow)
    );

    assign ex_mem_d = '{ctrl: id_ex_q.ctrl, alu_result: ex_result,
                        store_data: id_ex_q.rt_val};

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_inst (
        .clk   (clk),
        .rst   (rst),
        .hold  (1'b0),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // ====================
    // Memory and write-back
    data_memory data_memory_inst (
        .clk         (clk),
        .mem_read    (ex_mem_q.ctrl.mem_read),
        .mem_write   (ex_mem_q.ctrl.mem_write),
        .addr        (ex_mem_q.alu_result),
        .wdata       (ex_mem_q.store_data),
        .rdata       (),            // Only the merged result is needed here
        .load_or_alu (mem_result)
    );

    assign mem_wb_d = '{ctrl: ex_mem_q.ctrl, result: mem_result};

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_inst (
        .clk   (clk),
        .rst   (rst),
        .hold  (1'b0),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    assign wb_en   = mem_wb_q.ctrl.rf_wen;
    assign wb_addr = mem_wb_q.ctrl.rf_waddr;
    assign wb_data = mem_wb_q.result;
    assign syscall = mem_wb_q.ctrl.syscall;  // End of program marker

endmodule

// File: verilog/data_memory.sv
// Word-wide data memory
`timescale 1ns/10ps

module data_memory (
    input  logic                      clk,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic [mips_pkg::XLEN-1:0] addr,
    input  logic [mips_pkg::XLEN-1:0] wdata,
    output logic [mips_pkg::XLEN-1:0] rdata,
    output logic [mips_pkg::XLEN-1:0] load_or_alu
);
    import mips_pkg::*;

    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;

    assign idx = addr[DMEM_AW+1:2];  // Drop byte offset

    always_ff @(posedge clk) begin
        if (mem_write)
            mem[idx] <= wdata;
    end

    assign rdata       = mem[idx];
    assign load_or_alu = mem_read ? rdata : addr;  // MEM-stage result

    // Word accesses only
    assert property (@(posedge clk) (mem_read || mem_write) |-> addr[1:0] == 2'b00);

endmodule

// File: verilog/alu.sv
// Execute stage ALU
`timescale 1ns/10ps

module alu (
    input  mips_pkg::ctrl_t           ctrl,
    input  logic [mips_pkg::XLEN-1:0] rs_val,
    input  logic [mips_pkg::XLEN-1:0] rt_val,
    input  logic [15:0]               imm,
    output logic [mips_pkg::XLEN-1:0] result,
    output logic                      overflow
);
    import mips_pkg::*;

    logic [XLEN-1:0] op_b, sum, diff;
    logic            add_ovf, sub_ovf;

    always_comb begin
        if (!ctrl.use_imm)
            op_b = rt_val;
        else if (ctrl.imm_signed)
            op_b = {{(XLEN-16){imm[15]}}, imm};
        else
            op_b = {{(XLEN-16){1'b0}}, imm};
    end

    assign sum  = rs_val + op_b;
    assign diff = rs_val - op_b;

    // Sign flips only when inputs agree (add) or differ (sub)
    assign add_ovf  = (rs_val[XLEN-1] == op_b[XLEN-1]) && (sum[XLEN-1] != rs_val[XLEN-1]);
    assign sub_ovf  = (rs_val[XLEN-1] != op_b[XLEN-1]) && (diff[XLEN-1] != rs_val[XLEN-1]);
    assign overflow = ctrl.ovf_check && ((ctrl.alu_op == ALU_SUB) ? sub_ovf : add_ovf);

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB: result = diff;
            ALU_AND: result = rs_val & op_b;
            ALU_OR:  result = rs_val | op_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(rs_val) < $signed(op_b)};
            ALU_LUI: result = {imm, 16'b0};
            default: result = sum;  // add, addi, lw/sw address
        endcase
    end

endmodule

// File: verilog/hazard_forward.sv
// Load-use stall and decode operand forwarding
`timescale 1ns/10ps

module hazard_forward (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_id,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_id,
    input  mips_pkg::ctrl_t                 ex_ctrl,
    input  mips_pkg::ctrl_t                 mem_ctrl,
    input  mips_pkg::ctrl_t                 wb_ctrl,
    input  logic [mips_pkg::XLEN-1:0]       rf_rdata0,
    input  logic [mips_pkg::XLEN-1:0]       rf_rdata1,
    input  logic [mips_pkg::XLEN-1:0]       ex_result,
    input  logic [mips_pkg::XLEN-1:0]       mem_result,
    input  logic [mips_pkg::XLEN-1:0]       wb_data,
    output logic                            stall,
    output logic [mips_pkg::XLEN-1:0]       rs_val,
    output logic [mips_pkg::XLEN-1:0]       rt_val
);
    import mips_pkg::*;

    // Newest writer wins
    function automatic logic [XLEN-1:0] fwd(input logic [REG_ADDR_W-1:0] idx,
                                            input logic [XLEN-1:0]       rf_val);
        if (ex_ctrl.rf_wen && ex_ctrl.rf_waddr == idx)
            return ex_result;  // Live ALU output
        if (mem_ctrl.rf_wen && mem_ctrl.rf_waddr == idx)
            return mem_result;
        if (wb_ctrl.rf_wen && wb_ctrl.rf_waddr == idx)
            return wb_data;    // Register file not yet updated
        return rf_val;
    endfunction

    // Load data only exists from MEM onwards
    assign stall = ex_ctrl.mem_read && ex_ctrl.rf_wen &&
                   (ex_ctrl.rf_waddr == rs_id || ex_ctrl.rf_waddr == rt_id);

    always_comb begin
        rs_val = fwd(rs_id, rf_rdata0);
        rt_val = fwd(rt_id, rf_rdata1);
    end

    // ID/EX flush on stall leaves a bubble in EX next cycle
    assert property (@(posedge clk) disable iff (rst) stall |=> !stall);

endmodule

// File: verilog/reg_file.sv
// General purpose register file
`timescale 1ns/10ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wen,
    input  logic [mips_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [mips_pkg::XLEN-1:0]       wdata,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr0,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr1,
    output logic [mips_pkg::XLEN-1:0]       rdata0,
    output logic [mips_pkg::XLEN-1:0]       rdata1
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;  // $zero reads zero from here on
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write is seen through WB forwarding, not here
    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];

endmodule

// File: verilog/control_unit.sv
// Instruction decoder
`timescale 1ns/10ps

module control_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [mips_pkg::XLEN-1:0] inst,
    output mips_pkg::ctrl_t           ctrl,
    output logic                      is_beq,
    output logic                      is_bne,
    output logic                      is_jump
);
    import mips_pkg::*;

    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] dest;

    assign opcode = opcode_e'(inst[31:26]);
    assign funct  = funct_e'(inst[5:0]);

    always_comb begin
        ctrl    = '0;  // Anything unknown stays a bubble
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_jump = 1'b0;
        dest    = inst[20:16];  // rt for I-type
        case (opcode)
            OP_RTYPE: begin
                dest = inst[15:11];  // rd
                case (funct)
                    FN_ADD: begin
                        ctrl.alu_op    = ALU_ADD;
                        ctrl.ovf_check = 1'b1;
                        ctrl.rf_wen    = 1'b1;
                    end
                    FN_SUB: begin
                        ctrl.alu_op    = ALU_SUB;
                        ctrl.ovf_check = 1'b1;
                        ctrl.rf_wen    = 1'b1;
                    end
                    FN_AND: begin
                        ctrl.alu_op = ALU_AND;
                        ctrl.rf_wen = 1'b1;
                    end
                    FN_OR: begin
                        ctrl.alu_op = ALU_OR;
                        ctrl.rf_wen = 1'b1;
                    end
                    FN_SLT: begin
                        ctrl.alu_op = ALU_SLT;
                        ctrl.rf_wen = 1'b1;
                    end
                    FN_SYSCALL: ctrl.syscall = 1'b1;
                    default: ;
                endcase
            end
            OP_ADDI: begin
                ctrl.use_imm    = 1'b1;
                ctrl.imm_signed = 1'b1;
                ctrl.ovf_check  = 1'b1;
                ctrl.rf_wen     = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op  = ALU_LUI;  // Upper half built in the ALU
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen  = 1'b1;
            end
            OP_LW: begin
                ctrl.use_imm    = 1'b1;  // Address = rs + offset
                ctrl.imm_signed = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.rf_wen     = 1'b1;
            end
            OP_SW: begin
                ctrl.use_imm    = 1'b1;
                ctrl.imm_signed = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            OP_BEQ:  is_beq  = 1'b1;
            OP_BNE:  is_bne  = 1'b1;
            OP_J:    is_jump = 1'b1;
            default: ;
        endcase
        ctrl.rf_waddr = dest;
        if (dest == '0)
            ctrl.rf_wen = 1'b0;  // $zero is never written
    end

    // Programs only hold supported opcodes once out of reset
    assert property (@(posedge clk) disable iff (rst)
        opcode inside {OP_RTYPE, OP_J, OP_BEQ, OP_BNE, OP_ADDI, OP_LUI, OP_LW, OP_SW});

endmodule

// File: verilog/fetch_unit.sv
// Program counter and decode-stage redirect
`timescale 1ns/10ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      is_beq,
    input  logic                      is_bne,
    input  logic                      is_jump,
    input  logic [mips_pkg::XLEN-1:0] rs_val,
    input  logic [mips_pkg::XLEN-1:0] rt_val,
    input  logic [15:0]               imm,
    input  logic [25:0]               jump_index,
    input  logic [mips_pkg::XLEN-1:0] pc_plus_4_id,
    output logic [mips_pkg::XLEN-1:0] imem_addr,
    output logic [mips_pkg::XLEN-1:0] pc_plus_4,
    output logic                      redirect
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] branch_target, jump_target, next_pc;
    logic            taken;

    // Compare uses forwarded operands, so no extra branch stall
    assign taken    = (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
    assign redirect = !stall && (taken || is_jump);  // Operands may be stale while stalled

    assign branch_target = pc_plus_4_id + {{14{imm[15]}}, imm, 2'b00};
    assign jump_target   = {pc_plus_4_id[31:28], jump_index, 2'b00};  // Same 256 MB region

    assign pc_plus_4 = pc + XLEN'(4);
    assign imem_addr = pc;

    always_comb begin
        if (!redirect)
            next_pc = pc_plus_4;
        else if (is_jump)
            next_pc = jump_target;
        else
            next_pc = branch_target;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pc <= RESET_PC;
        else if (!stall)
            pc <= next_pc;  // Hold during load-use
    end

    // Squashed slot behind a redirect is a bubble and cannot redirect again
    assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect);

endmodule

// File: verilog/pipe_reg.sv
// Generic pipeline stage register
`timescale 1ns/10ps

module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t BUBBLE    = '0  // Control bits all clear
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            q <= BUBBLE;
        else if (flush)
            q <= BUBBLE;
        else if (!hold)
            q <= d;
    end

    // Stall and redirect never hit the same stage at once
    assert property (@(posedge clk) disable iff (rst) !(hold && flush));

endmodule

// File: verilog/mips_pkg.sv
// MIPS pipeline shared definitions
package mips_pkg;

    // ====================
    // Widths and sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // Word index bits
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // ====================
    // Instruction codes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        FN_SYSCALL = 6'h0c,
        FN_ADD     = 6'h20,
        FN_SUB     = 6'h22,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_SLT     = 6'h2a
    } funct_e;

    // ====================
    // Control and stage payloads
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,  // Zero so a bubble is harmless
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e                 alu_op;
        logic                    use_imm;     // Immediate replaces rt
        logic                    imm_signed;
        logic                    ovf_check;   // add, addi, sub
        logic                    mem_read;
        logic                    mem_write;
        logic                    rf_wen;
        logic [REG_ADDR_W-1:0]   rf_waddr;
        logic                    syscall;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc_plus_4;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       rs_val;  // Already forwarded in decode
        logic [XLEN-1:0]       rt_val;
        logic [15:0]           imm;
        logic [REG_ADDR_W-1:0] rt;
    } id_ex_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] result;  // Load data or ALU result
    } mem_wb_t;

endpackage
